// ==== dv/slice_patterns.mem ====
// Columns: payload word (hex), master stall mask (hex), mask bit n stalls cycle n of its window
// A zero mask hands the stall bits for its 32-cycle window to the testbench LFSR
00000001 00000000
deadbeef 0000ff00
a5a5a5a5 f0f0f0f0
5a5a5a5a 00000000
12345678 0f0f0f0f
87654321 aaaaaaaa
ffffffff 55555555
00000000 00000000
c001d00d 33333333
0badf00d cccccccc
13579bdf 00ff00ff
2468ace0 00000000
fedcba98 ff00ff00
01234567 11111111
76543210 88888888
80000000 00000000
00000080 7777eeee
0f0f0f0f 0000ffff
f0f0f0f0 ffff0000
3c3c3c3c 00000000
c3c3c3c3 12481248
aa55aa55 84218421
55aa55aa 00000000
11223344 6db6db6d
55667788 92492492
99aabbcc 00000000
ddeeff00 e38e38e3
cafebabe 1c71c71c
feedface 00000000
b16b00b5 f00ff00f
0ff1ce00 0ff00ff0
abcdef01 00000000
10203040 3f3f3f3f
50607080 c0c0c0c0
7fffffff 00000000
fffffffe 01010101

// ==== si_reg_slice.f ====
rtl/slice_pkg.sv
rtl/si_capture.sv
rtl/fill_ctrl_fsm.sv
rtl/fill_counter.sv
rtl/payload_store.sv
rtl/si_reg_slice.sv
dv/si_reg_slice_tb.sv

// ==== Bender.yml ====
package:
  name: si_reg_slice

sources:
  # Design
  - rtl/slice_pkg.sv
  - rtl/si_capture.sv
  - rtl/fill_ctrl_fsm.sv
  - rtl/fill_counter.sv
  - rtl/payload_store.sv
  - rtl/si_reg_slice.sv
  # Testbench
  - target: simulation
    files:
      - dv/si_reg_slice_tb.sv

// ==== dv/si_reg_slice_tb.sv ====
// Self-checking testbench for the source-registered slice, stimulus taken from the pattern file
`timescale 1ns/1ns

module si_reg_slice_tb;

  import slice_pkg::*;

  localparam int          N_PAT     = 36;       // Lines in the pattern file
  localparam int          TIMEOUT   = 4000;     // Cycles allowed per wait
  localparam int          STALL_CYC = 12;       // Master held off in the stall test
  localparam logic [31:0] SEED      = 32'h2851;

  logic     ACLK;
  logic     ARESET;
  logic     s_valid_i;
  payload_t s_payload_i;
  logic     s_ready_o;
  logic     m_valid_o;
  payload_t m_payload_o;
  logic     m_ready_i;

  logic [31:0] pat_mem [2*N_PAT]; // Payload, mask, payload, mask ...
  logic [31:0] lfsr;
  payload_t    sb_q [$];          // Accepted, not yet delivered
  payload_t    hold_data;         // Output seen while stalled
  logic        hold_pend;
  logic        mon_en;
  logic        aborted;           // A wait ran out or the patterns are bad
  int          item_idx;          // Next item to present
  int          rcyc;              // Master stall cycle index
  int          acc_cnt;
  int          deliv_cnt;
  int          gap_cnt;           // Idle master cycles with work owed
  int          ready_low_cnt;     // Slave cycles offered but not taken
  int          hold_cnt;
  int          chk_cnt;
  int          err_cnt;

  si_reg_slice uut (
    .ACLK        (ACLK),
    .ARESET      (ARESET),
    .s_valid_i   (s_valid_i),
    .s_payload_i (s_payload_i),
    .s_ready_o   (s_ready_o),
    .m_valid_o   (m_valid_o),
    .m_payload_o (m_payload_o),
    .m_ready_i   (m_ready_i)
  );

  initial begin
    ACLK = 1'b0;
    forever #5 ACLK = ~ACLK; // 10 ns period
  end

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////
  task automatic check_payload(input string name, input payload_t exp, input payload_t act);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("mismatch %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("mismatch %s expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input fill_cnt_t exp, input fill_cnt_t act);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("mismatch %s expected %0d actual %0d", name, exp, act);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////
  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bit(output logic b);
    lfsr = lfsr_next(lfsr);
    b    = lfsr[0];
  endtask

  // Later passes over the file get a per-pass offset
  function automatic payload_t payload_for(input int i);
    return payload_t'(pat_mem[2*(i % N_PAT)]) ^ (payload_t'(i / N_PAT) * 32'h0101_0101);
  endfunction

  // Mask bit set means master not ready this cycle
  task automatic next_ready(output logic rdy);
    logic [31:0] mask;
    logic        b;
    mask = pat_mem[2*((rcyc / 32) % N_PAT) + 1];
    if (mask == 32'h0) begin
      draw_bit(b); // Zero mask hands over to the LFSR
    end else begin
      b = mask[rcyc % 32];
    end
    rdy = ~b;
    rcyc++;
  endtask

  // One rising edge of slave and master driving
  task automatic drive_cycle(input int last, input logic gaps, input logic rdy);
    logic go;
    if (s_valid_i && s_ready_o) begin
      item_idx++; // Taken on this edge
    end
    if (!s_valid_i || s_ready_o) begin // Presented item stays until taken
      go = 1'b1;
      if (gaps) begin
        draw_bit(go);
      end
      if (item_idx < last && go) begin
        s_valid_i   <= 1'b1;
        s_payload_i <= payload_for(item_idx);
      end else begin
        s_valid_i <= 1'b0;
      end
    end
    m_ready_i <= rdy;
  endtask

  // Send items up to last and wait for the scoreboard to empty
  task automatic run_items(input string what, input int last, input logic gaps,
                           input logic rand_rdy);
    int   n;
    logic rdy;
    n = 0;
    while (!aborted && (item_idx < last || sb_q.size() != 0)) begin
      if (n >= TIMEOUT) begin
        timeout_abort(what);
      end else begin
        @(posedge ACLK);
        rdy = 1'b1;
        if (rand_rdy) begin
          next_ready(rdy);
        end
        drive_cycle(last, gaps, rdy);
        n++;
      end
    end
  endtask

  task automatic test_done(input string name, input int err_mark);
    $display("test %s finished, %0d errors", name, err_cnt - err_mark);
  endtask

  task automatic timeout_abort(input string what);
    $display("timeout, no progress in %s within %0d cycles", what, TIMEOUT);
    aborted = 1'b1;
  endtask

  task automatic finish_run;
    $display("checks %0d, errors %0d, items delivered %0d", chk_cnt, err_cnt, deliv_cnt);
    if (err_cnt == 0 && !aborted) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  endtask

  ////////////////////////////////////////////////////////////
  // Scoreboard and hold monitor, sampled mid-cycle
  ////////////////////////////////////////////////////////////
  always @(negedge ACLK) begin : monitor
    payload_t exp;
    if (mon_en) begin
      if (hold_pend) begin // Stalled output must not move
        check_flag("hold_valid", 1'b1, m_valid_o);
        check_payload("hold_payload", hold_data, m_payload_o);
        hold_cnt++;
      end
      hold_pend = m_valid_o && !m_ready_i;
      hold_data = m_payload_o;
      if (m_valid_o && m_ready_i) begin
        deliv_cnt++;
        if (sb_q.size() == 0) begin
          err_cnt++;
          $display("output %h delivered with nothing outstanding", m_payload_o);
        end else begin
          exp = sb_q.pop_front();
          check_payload("order", exp, m_payload_o);
        end
      end else if (sb_q.size() != 0 && m_ready_i) begin
        gap_cnt++; // Item owed, master side idle
      end
      if (s_valid_i && !s_ready_o) begin
        ready_low_cnt++;
      end
      if (s_valid_i && s_ready_o) begin
        sb_q.push_back(s_payload_i);
        acc_cnt++;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////
  task automatic exercise_dut;
    int n;
    int err_mark;
    int acc_mark;
    int last;
    // Reset, outputs quiet then ready comes up
    err_mark = err_cnt;
    repeat (4) @(posedge ACLK);
    @(negedge ACLK);
    check_flag("reset_ready", 1'b0, s_ready_o);
    check_flag("reset_valid", 1'b0, m_valid_o);
    @(posedge ACLK);
    ARESET <= 1'b0; // Fifth edge still in reset
    mon_en = 1'b1;
    n      = 0;
    @(negedge ACLK);
    while (!aborted && s_ready_o !== 1'b1) begin
      if (n >= TIMEOUT) begin
        timeout_abort("s_ready_o rising after reset");
      end else begin
        @(negedge ACLK);
        n++;
      end
    end
    check_flag("idle_valid", 1'b0, m_valid_o);
    test_done("reset", err_mark);

    // Streaming, master always ready
    err_mark      = err_cnt;
    gap_cnt       = 0;
    ready_low_cnt = 0;
    run_items("stream", N_PAT, 1'b0, 1'b0);
    check_flag("stream_gapless", 1'b1, gap_cnt == 0);
    check_flag("stream_ready", 1'b1, ready_low_cnt == 0); // One accepted every cycle
    test_done("stream", err_mark);

    // Full stall from empty, then release
    err_mark = err_cnt;
    acc_mark = acc_cnt;
    last     = item_idx + 8;
    repeat (STALL_CYC) begin
      @(posedge ACLK);
      drive_cycle(last, 1'b0, 1'b0);
    end
    @(negedge ACLK);
    check_count("stall_accepted", fill_cnt_t'(MAX_HELD), fill_cnt_t'(acc_cnt - acc_mark));
    check_count("stall_held", fill_cnt_t'(MAX_HELD), fill_cnt_t'(sb_q.size()));
    check_flag("stall_ready", 1'b0, s_ready_o);
    check_flag("stall_valid", 1'b1, m_valid_o);
    run_items("stall drain", last, 1'b0, 1'b0);
    test_done("stall", err_mark);
    check_flag("hold_seen", 1'b1, hold_cnt > 0);
    test_done("hold", err_mark);

    // Random master stalls and slave gaps
    err_mark = err_cnt;
    last     = item_idx + 3 * N_PAT;
    run_items("random", last, 1'b1, 1'b1);
    @(negedge ACLK);
    check_flag("drain_valid", 1'b0, m_valid_o);
    test_done("random", err_mark);
  endtask

  initial begin
    ARESET        = 1'b1;
    s_valid_i     = 1'b0;
    s_payload_i   = '0;
    m_ready_i     = 1'b0;
    lfsr          = SEED;
    mon_en        = 1'b0;
    aborted       = 1'b0;
    hold_pend     = 1'b0;
    hold_data     = '0;
    item_idx      = 0;
    rcyc          = 0;
    acc_cnt       = 0;
    deliv_cnt     = 0;
    gap_cnt       = 0;
    ready_low_cnt = 0;
    hold_cnt      = 0;
    chk_cnt       = 0;
    err_cnt       = 0;
    $readmemh("dv/slice_patterns.mem", pat_mem);
    if (^pat_mem[2*N_PAT-1] === 1'bx) begin
      $display("pattern file dv/slice_patterns.mem is missing or short");
      aborted = 1'b1;
    end else begin
      exercise_dut();
    end
    finish_run();
  end

endmodule

// ==== rtl/si_reg_slice.sv ====
// Top of the source-registered stream slice; connects capture, fill control, counter and store
`timescale 1ns/1ns

module si_reg_slice (
  input  logic                ACLK,
  input  logic                ARESET,
  // Slave side
  input  logic                s_valid_i,
  input  slice_pkg::payload_t s_payload_i,
  output logic                s_ready_o,
  // Master side
  output logic                m_valid_o,
  output slice_pkg::payload_t m_payload_o,
  input  logic                m_ready_i
);

  import slice_pkg::*;

  payload_t          payload_d;  // Registered slave payload
  logic              hs_d;       // Late slave handshake
  fill_cnt_t         fill_state;
  logic [ADDR_W-1:0] rd_addr;
  logic              push;
  logic              pop;
  logic              sel_store;
  logic              rst_d;

  ////////////////////////////////////////////////////////////
  // Input stage
  ////////////////////////////////////////////////////////////
  si_capture u_capture (
    .ACLK        (ACLK),
    .ARESET      (ARESET),
    .s_valid_i   (s_valid_i),
    .s_payload_i (s_payload_i),
    .s_ready_i   (s_ready_o),   // Ready loops back for the late handshake
    .payload_d_o (payload_d),
    .hs_d_o      (hs_d)
  );

  ////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////
  fill_ctrl_fsm u_ctrl (
    .ACLK         (ACLK),
    .ARESET       (ARESET),
    .hs_d_i       (hs_d),
    .m_ready_i    (m_ready_i),
    .fill_state_i (fill_state),
    .push_o       (push),
    .pop_o        (pop),
    .sel_store_o  (sel_store),
    .s_ready_o    (s_ready_o),
    .m_valid_o    (m_valid_o),
    .rst_d_o      (rst_d)
  );

  fill_counter u_counter (
    .ACLK         (ACLK),
    .rst_d_i      (rst_d),
    .push_i       (push),
    .pop_i        (pop),
    .fill_state_o (fill_state),
    .rd_addr_o    (rd_addr)
  );

  ////////////////////////////////////////////////////////////
  // Data path
  ////////////////////////////////////////////////////////////
  payload_store u_store (
    .ACLK        (ACLK),
    .push_i      (push),
    .rd_addr_i   (rd_addr),
    .sel_store_i (sel_store),
    .payload_d_i (payload_d),
    .m_payload_o (m_payload_o)
  );

endmodule

// ==== rtl/payload_store.sv ====
// Shift-register payload store with addressed read and the master payload select
`timescale 1ns/1ns

module payload_store (
  input  logic                         ACLK,
  input  logic                         push_i,
  input  logic [slice_pkg::ADDR_W-1:0] rd_addr_i,
  input  logic                         sel_store_i,
  input  slice_pkg::payload_t          payload_d_i,
  output slice_pkg::payload_t          m_payload_o
);

  import slice_pkg::*;

  payload_t store_out; // Entry at the read address

  ////////////////////////////////////////////////////////////
  // One shift chain per payload bit
  ////////////////////////////////////////////////////////////
  for (genvar i = 0; i < DATA_W; i++) begin : gen_bit
    logic [STORE_DEPTH-1:0] srl_q; // Index 0 is the newest entry

    // No reset, content is qualified by the fill level
    always_ff @(posedge ACLK) begin
      if (push_i) begin
        srl_q <= {srl_q[STORE_DEPTH-2:0], payload_d_i[i]};
      end
    end

    assign store_out[i] = srl_q[rd_addr_i]; // Combinational read
  end

  // Empty path bypasses the store
  assign m_payload_o = sel_store_i ? store_out : payload_d_i;

endmodule

// ==== rtl/fill_counter.sv ====
// Up/down fill-level counter for the slice; low bits address the payload store
`timescale 1ns/1ns

module fill_counter (
  input  logic                     ACLK,
  input  logic                     rst_d_i,   // Delayed reset from the FSM
  input  logic                     push_i,
  input  logic                     pop_i,
  output slice_pkg::fill_cnt_t     fill_state_o,
  output logic [slice_pkg::ADDR_W-1:0] rd_addr_o
);

  import slice_pkg::*;

  fill_cnt_t cnt_q; // Current fill code

  always_ff @(posedge ACLK) begin
    if (rst_d_i) begin
      cnt_q <= FILL_RESET;
    end else if (push_i && !pop_i) begin
      cnt_q <= cnt_q + 3'd1; // Reset -> empty -> one ... wraps through 111
    end else if (pop_i && !push_i) begin
      cnt_q <= cnt_q - 3'd1;
    end
  end

  assign fill_state_o = cnt_q;
  assign rd_addr_o    = cnt_q[ADDR_W-1:0]; // Oldest entry sits at this index

endmodule

// ==== rtl/fill_ctrl_fsm.sv ====
// Fill control FSM; decodes fill level and handshakes into push/pop, ready and valid
`timescale 1ns/1ns

module fill_ctrl_fsm (
  input  logic                ACLK,
  input  logic                ARESET,
  input  logic                hs_d_i,      // Late slave handshake
  input  logic                m_ready_i,
  input  slice_pkg::fill_cnt_t fill_state_i,
  output logic                push_o,
  output logic                pop_o,
  output logic                sel_store_o, // 1 serves master from store
  output logic                s_ready_o,
  output logic                m_valid_o,
  output logic                rst_d_o      // Delayed reset for the counter
);

  import slice_pkg::*;

  fill_state_e state;       // Current fill level as enum
  logic        rst_d;       // ARESET one cycle late
  logic        s_ready_q;   // Registered slave ready
  logic        s_ready_nxt; // Ready for the next cycle

  assign state = fill_state_e'(fill_state_i);

  ////////////////////////////////////////////////////////////
  // Reset delay and registered ready
  ////////////////////////////////////////////////////////////
  always_ff @(posedge ACLK) begin
    rst_d <= ARESET; // Plain delay, control sees reset late
  end

  always_ff @(posedge ACLK) begin
    if (rst_d) begin
      s_ready_q <= 1'b0;
    end else begin
      s_ready_q <= s_ready_nxt;
    end
  end

  ////////////////////////////////////////////////////////////
  // State decode
  ////////////////////////////////////////////////////////////
  always_comb begin
    // Defaults match the occupied states
    push_o      = 1'b0;
    pop_o       = 1'b0;
    sel_store_o = 1'b1;
    s_ready_nxt = 1'b0;
    m_valid_o   = 1'b1;
    case (state)
      FILL_EMPTY: begin
        sel_store_o = 1'b0;                  // Straight from input register
        s_ready_nxt = 1'b1;
        m_valid_o   = hs_d_i;
        push_o      = hs_d_i & ~m_ready_i;   // Keep it only if master stalls
      end
      FILL_ONE: begin
        push_o      = hs_d_i;
        pop_o       = m_ready_i;
        s_ready_nxt = ~hs_d_i | m_ready_i;   // Drop on push without pop
      end
      FILL_TWO: begin
        push_o      = hs_d_i;
        pop_o       = m_ready_i;
        // Room for the skid item only after a lone pop
        s_ready_nxt = ~hs_d_i & m_ready_i;
      end
      FILL_THREE: begin
        pop_o = m_ready_i; // Full, nothing accepted
      end
      default: begin
        // Reset code, step the counter to empty
        sel_store_o = 1'b0;
        m_valid_o   = 1'b0;
        push_o      = 1'b1;
      end
    endcase
  end

  assign s_ready_o = s_ready_q;
  assign rst_d_o   = rst_d;

endmodule

// ==== rtl/si_capture.sv ====
// Slave-side input register stage, forms the one-cycle-late slave handshake for the control logic
`timescale 1ns/1ns

module si_capture (
  input  logic              ACLK,
  input  logic              ARESET,
  input  logic              s_valid_i,
  input  slice_pkg::payload_t s_payload_i,
  input  logic              s_ready_i,   // Registered slave ready from the FSM
  output slice_pkg::payload_t payload_d_o,
  output logic              hs_d_o
);

  logic s_valid_d; // Slave valid, one cycle late
  logic s_ready_d; // Copy of the registered ready

  // Payload taken every cycle, no enable needed
  always_ff @(posedge ACLK) begin
    payload_d_o <= s_payload_i;
  end

  // Control half of the input stage
  always_ff @(posedge ACLK) begin
    if (ARESET) begin
      s_valid_d <= 1'b0;
      s_ready_d <= 1'b0;
    end else begin
      s_valid_d <= s_valid_i;
      s_ready_d <= s_ready_i; // Lines up with the registered valid
    end
  end

  // Handshake that completed on the previous edge
  assign hs_d_o = s_valid_d & s_ready_d;

endmodule

// ==== rtl/slice_pkg.sv ====
// Shared widths, store depth and fill-state codes for the source-registered slice
package slice_pkg;

  ////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////
  localparam int DATA_W      = 32; // Payload bit width
  localparam int STORE_DEPTH = 4;  // Store entries
  localparam int ADDR_W      = 2;  // Store address bits
  localparam int MAX_HELD    = 3;  // Store capacity

  ////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////
  typedef logic [DATA_W-1:0] payload_t; // One payload word
  typedef logic [2:0]        fill_cnt_t; // Fill-level code

  // Fill state, low two bits double as the store read address
  typedef enum fill_cnt_t {
    FILL_RESET = 3'b110, // Waiting to leave reset
    FILL_EMPTY = 3'b111, // Nothing held
    FILL_ONE   = 3'b000, // One item in store
    FILL_TWO   = 3'b001, // Two items
    FILL_THREE = 3'b010  // Full
  } fill_state_e;

endpackage
